/* archie_support_top.f */
hw/archie_cfg_pkg.sv
hw/archie_bus_pkg.sv
hw/clken_gen.sv
hw/sys_ctrl.sv
hw/loader_bridge.sv
hw/porch_blanker.sv
hw/archie_support_top.sv
test/archie_support_asserts.sv
test/tb_archie_support.sv

/* Bender.yml */
package:
  name: archie_support

sources:
  - hw/archie_cfg_pkg.sv
  - hw/archie_bus_pkg.sv
  - hw/clken_gen.sv
  - hw/sys_ctrl.sv
  - hw/loader_bridge.sv
  - hw/porch_blanker.sv
  - hw/archie_support_top.sv
  - target: test
    files:
      - test/archie_support_asserts.sv
      - test/tb_archie_support.sv

/* test/tb_archie_support.sv */
module tb_archie_support
	import archie_cfg_pkg::*;
	import archie_bus_pkg::*;
;

	localparam int TIMEOUT = 200;

	logic clk_sys = 1'b0;
	logic reset_i;
	logic clk2m_en_o, clk8m_en_o;
	logic dl_active_i, dl_wr_i, ram_ready_i, button_reset_i, core_reset_o;
	dl_index_t dl_index_i;
	logic [DL_ADR_W-1:0] dl_addr_i;
	logic [7:0] dl_data_i;
	logic core_cyc_i, core_stb_i, core_we_i, core_ack_o;
	logic [WB_SEL_W-1:0] core_sel_i, ram_sel_o;
	logic [WB_ADR_W-1:0] core_adr_i, ram_adr_o;
	logic [WB_DATA_W-1:0] core_dat_i, core_dat_o, ram_dat_o, ram_dat_i;
	logic ram_cyc_o, ram_stb_o, ram_we_o, ram_ack_i;
	pixclk_sel_t pixbase_sel_i;
	logic pll_busy_i, pll_write_from_rom_o, pll_reconfig_o, pll_reset_o, pix_clk_ena_o;
	logic ce_pix_i, hs_i, vs_i, hs_o, vs_o;
	logic [COLOR_W-1:0] r_i, g_i, b_i, r_o, g_o, b_o;

	logic [31:0] rng = 32'h1bd6_e0ea;
	int timeouts = 0;
	int compares = 0;
	int ack_wait = 0;
	int total;

	archie_support_top archie_support_top_inst (.*);

	always #5 clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	// memory slave with random ack latency
	always @(negedge clk_sys) begin
		if (reset_i) begin
			ram_ack_i <= 1'b0;
		end else if (ram_ack_i) begin
			ram_ack_i <= 1'b0;
		end else if (ram_stb_o) begin
			if (ack_wait == 0) begin
				ram_ack_i <= 1'b1;
				ram_dat_i <= rand32();
				ack_wait  = rand32() % 4;
			end else begin
				ack_wait--;
			end
		end
	end

	task automatic wait_high(input int which, input int limit, input string what);
		int n;
		logic hit;
		n = 0;
		hit = 1'b0;
		while (!hit && n < limit) begin
			@(negedge clk_sys);
			case (which)
				0: hit = ram_ack_i;
				1: hit = pll_write_from_rom_o;
				2: hit = pll_reconfig_o;
				3: hit = pix_clk_ena_o;
				default: hit = pll_reset_o;
			endcase
			n++;
		end
		if (!hit) begin
			$display("timeout while waiting for %s", what);
			timeouts++;
		end
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			compares++;
		end
	endtask

	task automatic core_access(input int count);
		repeat (count) begin
			@(negedge clk_sys);
			core_cyc_i <= 1'b1;
			core_stb_i <= 1'b1;
			core_we_i  <= 1'(rand32());
			core_sel_i <= WB_SEL_W'(rand32());
			core_adr_i <= WB_ADR_W'(rand32());
			core_dat_i <= rand32();
			wait_high(0, TIMEOUT, "core ack");
			core_cyc_i <= 1'b0;
			core_stb_i <= 1'b0;
		end
	endtask

	task automatic loader_bytes(input int count);
		repeat (count) begin
			@(negedge clk_sys);
			dl_wr_i   <= 1'b1;
			dl_addr_i <= DL_ADR_W'(rand32());
			dl_data_i <= 8'(rand32());
			@(negedge clk_sys);
			dl_wr_i <= 1'b0;
			wait_high(0, TIMEOUT, "loader ack");
		end
	endtask

	task automatic video_lines(input int count);
		repeat (count) begin
			for (int c = 0; c < 400; c++) begin
				@(negedge clk_sys);
				ce_pix_i <= 1'(rand32());
				hs_i     <= (c >= 40);
				vs_i     <= (c < 20);
				r_i      <= COLOR_W'(rand32());
				g_i      <= COLOR_W'(rand32());
				b_i      <= COLOR_W'(rand32());
			end
		end
	endtask

	initial begin
		reset_i = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i = dl_menu;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		ram_ready_i = 1'b0;
		button_reset_i = 1'b0;
		core_cyc_i = 1'b0;
		core_stb_i = 1'b0;
		core_we_i = 1'b0;
		core_sel_i = '0;
		core_adr_i = '0;
		core_dat_i = '0;
		ram_ack_i = 1'b0;
		ram_dat_i = '0;
		pixbase_sel_i = pix_36;
		pll_busy_i = 1'b0;
		ce_pix_i = 1'b0;
		hs_i = 1'b0;
		vs_i = 1'b0;
		r_i = '0;
		g_i = '0;
		b_i = '0;
		repeat (4) @(negedge clk_sys);
		reset_i <= 1'b0;
		repeat (60) @(negedge clk_sys);

		// boot: core held until a ROM load ends
		ram_ready_i <= 1'b1;
		core_access(6);
		dl_active_i <= 1'b1;
		dl_index_i  <= dl_cmos;
		core_access(4);
		@(negedge clk_sys);
		compare("core_reset_o", 32'(core_reset_o), 32'd1);
		dl_index_i <= dl_rom_a;
		loader_bytes(8);
		dl_index_i <= dl_rom_b;
		loader_bytes(4);
		dl_active_i <= 1'b0;
		repeat (4) @(negedge clk_sys);
		compare("core_reset_o", 32'(core_reset_o), 32'd0);
		button_reset_i <= 1'b1;
		@(negedge clk_sys);
		compare("core_reset_o", 32'(core_reset_o), 32'd1);
		button_reset_i <= 1'b0;
		core_access(4);

		// reconfiguration with a quiet PLL
		pixbase_sel_i <= pix_25;
		wait_high(1, 10, "ROM load pulse");
		wait_high(2, 10, "reconfig pulse");
		wait_high(3, 10, "pixel clock enable");

		// busy before and after the reconfig pulse
		pll_busy_i <= 1'b1;
		pixbase_sel_i <= pix_24;
		wait_high(1, 10, "ROM load pulse");
		repeat (5) @(negedge clk_sys);
		pll_busy_i <= 1'b0;
		wait_high(2, 10, "reconfig pulse");
		pll_busy_i <= 1'b1;
		wait_high(4, RECONFIG_TIMEOUT_DEF + 2, "PLL reset after watchdog");
		pll_busy_i <= 1'b0;
		wait_high(3, 10, "pixel clock enable");

		// TV mode porch, then VGA mode porch
		video_lines(2);
		pixbase_sel_i <= pix_25;
		wait_high(3, 10, "pixel clock enable");
		video_lines(2);
		repeat (4) @(negedge clk_sys);

		total = timeouts + compares + archie_support_top_inst.asserts_inst.assert_errs;
		$display("errors: %0d timeouts, %0d compares, %0d assertions", timeouts, compares,
			archie_support_top_inst.asserts_inst.assert_errs);
		if (total == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* test/archie_support_asserts.sv */
module archie_support_asserts
	import archie_cfg_pkg::*;
	import archie_bus_pkg::*;
(
	input logic                 clk_sys,
	input logic                 reset_i,
	input logic                 clk2m_en_o,
	input logic                 clk8m_en_o,
	input logic                 dl_active_i,
	input dl_index_t            dl_index_i,
	input logic                 dl_wr_i,
	input logic [DL_ADR_W-1:0]  dl_addr_i,
	input logic [7:0]           dl_data_i,
	input logic                 ram_ready_i,
	input logic                 button_reset_i,
	input logic                 core_reset_o,
	input logic                 core_cyc_i,
	input logic                 core_stb_i,
	input logic                 core_we_i,
	input logic [WB_SEL_W-1:0]  core_sel_i,
	input logic [WB_ADR_W-1:0]  core_adr_i,
	input logic [WB_DATA_W-1:0] core_dat_i,
	input logic [WB_DATA_W-1:0] core_dat_o,
	input logic                 core_ack_o,
	input logic                 ram_cyc_o,
	input logic                 ram_stb_o,
	input logic                 ram_we_o,
	input logic [WB_SEL_W-1:0]  ram_sel_o,
	input logic [WB_ADR_W-1:0]  ram_adr_o,
	input logic [WB_DATA_W-1:0] ram_dat_o,
	input logic                 ram_ack_i,
	input logic [WB_DATA_W-1:0] ram_dat_i,
	input pixclk_sel_t          pixbase_sel_i,
	input logic                 pll_busy_i,
	input logic                 pll_write_from_rom_o,
	input logic                 pll_reconfig_o,
	input logic                 pll_reset_o,
	input logic                 pix_clk_ena_o,
	input logic                 ce_pix_i,
	input logic                 hs_i,
	input logic                 vs_i,
	input logic                 hs_o,
	input logic                 vs_o,
	input logic [COLOR_W-1:0]   r_i,
	input logic [COLOR_W-1:0]   g_i,
	input logic [COLOR_W-1:0]   b_i,
	input logic [COLOR_W-1:0]   r_o,
	input logic [COLOR_W-1:0]   g_o,
	input logic [COLOR_W-1:0]   b_o
);

	int assert_errs = 0;

	logic                owns;
	logic                owns_q;
	logic                rom_seen;
	logic [DL_ADR_W-1:0] exp_addr;
	logic [7:0]          exp_byte;
	logic [8:0]          hi_cnt;
	logic [8:0]          limit;

	// ROM images only take the bus
	assign owns  = dl_active_i && (dl_index_i == dl_rom_a || dl_index_i == dl_rom_b);
	assign limit = (pixbase_sel_i[0] == pixbase_sel_i[1]) ? 9'd255 : 9'd63;

	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) begin
			exp_addr <= dl_addr_i;
			exp_byte <= dl_data_i;
		end
	end

	// a ROM download has finished since reset
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			owns_q   <= 1'b0;
			rom_seen <= 1'b0;
		end else begin
			owns_q <= owns;
			if (owns_q && !owns)
				rom_seen <= 1'b1;
		end
	end

	// clocks since the registered hsync went high
	always_ff @(posedge clk_sys) begin
		if (reset_i || !hs_o)
			hi_cnt <= '0;
		else if (hi_cnt != 9'h1ff)
			hi_cnt <= hi_cnt + 1'b1;
	end

	a_en_reset: assert property (@(posedge clk_sys)
		reset_i |=> !clk2m_en_o && !clk8m_en_o)
		else begin $error("clock enable high during reset"); assert_errs++; end
	a_en_2m: assert property (@(posedge clk_sys) disable iff (reset_i)
		clk2m_en_o |=> !clk2m_en_o [*19] ##1 clk2m_en_o)
		else begin $error("2 MHz enable period wrong"); assert_errs++; end
	a_en_8m: assert property (@(posedge clk_sys) disable iff (reset_i)
		clk8m_en_o |=> !clk8m_en_o [*4] ##1 clk8m_en_o)
		else begin $error("8 MHz enable period wrong"); assert_errs++; end

	a_dl_rule: assert property (@(posedge clk_sys) disable iff (reset_i)
		dl_wr_i && owns |-> !ram_stb_o)
		else begin $error("loader byte before previous ack"); assert_errs++; end
	a_dl_start: assert property (@(posedge clk_sys) disable iff (reset_i)
		dl_wr_i && owns |=> ram_stb_o && ram_cyc_o && ram_we_o)
		else begin $error("loader cycle did not start"); assert_errs++; end
	a_dl_hold: assert property (@(posedge clk_sys) disable iff (reset_i)
		owns && ram_stb_o && !ram_ack_i |=> ram_stb_o && ram_cyc_o)
		else begin $error("loader strobe dropped before ack"); assert_errs++; end
	a_dl_end: assert property (@(posedge clk_sys) disable iff (reset_i)
		owns && ram_stb_o && ram_ack_i && !dl_wr_i |=> !ram_stb_o && !ram_cyc_o)
		else begin $error("loader strobe held after ack"); assert_errs++; end
	a_dl_lanes: assert property (@(posedge clk_sys) disable iff (reset_i)
		owns && ram_stb_o |-> $onehot(ram_sel_o) && ram_sel_o[exp_addr[1:0]] &&
			ram_dat_o == {4{exp_byte}} &&
			ram_adr_o == (WB_ADR_W'(exp_addr) & ~WB_ADR_W'(3)) && ram_we_o)
		else begin $error("loader lane, data or address wrong"); assert_errs++; end
	a_dl_no_core_ack: assert property (@(posedge clk_sys) disable iff (reset_i)
		owns |-> !core_ack_o)
		else begin $error("core ack while loader owns bus"); assert_errs++; end

	a_core_pass: assert property (@(posedge clk_sys) disable iff (reset_i)
		!owns |-> ram_cyc_o == core_cyc_i && ram_stb_o == core_stb_i &&
			ram_we_o == core_we_i && ram_sel_o == core_sel_i &&
			ram_dat_o == core_dat_i && core_ack_o == ram_ack_i &&
			ram_adr_o == (core_adr_i & ~WB_ADR_W'(3)))
		else begin $error("core pass-through mismatch"); assert_errs++; end
	a_rdata: assert property (@(posedge clk_sys) disable iff (reset_i)
		core_dat_o == ram_dat_i)
		else begin $error("read data not passed to core"); assert_errs++; end

	a_boot_release: assert property (@(posedge clk_sys) disable iff (reset_i)
		$fell(owns) && !rom_seen && ram_ready_i && !button_reset_i
			|=> core_reset_o ##1 !core_reset_o)
		else begin $error("core reset not released two cycles after ROM load"); assert_errs++; end
	a_boot_hold: assert property (@(posedge clk_sys) disable iff (reset_i)
		button_reset_i || !ram_ready_i || !rom_seen |-> core_reset_o)
		else begin $error("core reset low before boot conditions met"); assert_errs++; end

	a_rc_gate: assert property (@(posedge clk_sys) disable iff (reset_i)
		pll_write_from_rom_o == $fell(pix_clk_ena_o))
		else begin $error("pixel clock gate and ROM load pulse out of step"); assert_errs++; end
	a_rc_pulses: assert property (@(posedge clk_sys) disable iff (reset_i)
		pll_write_from_rom_o || pll_reconfig_o || pll_reset_o
			|=> !pll_write_from_rom_o && !pll_reconfig_o && !pll_reset_o)
		else begin $error("PLL control pulse longer than one cycle"); assert_errs++; end
	a_rc_start: assert property (@(posedge clk_sys) disable iff (reset_i)
		pll_write_from_rom_o ##1 !pll_busy_i |=> pll_reconfig_o)
		else begin $error("reconfig pulse missing after idle PLL"); assert_errs++; end
	a_rc_busy: assert property (@(posedge clk_sys) disable iff (reset_i)
		pll_reconfig_o |-> $past(!pll_busy_i))
		else begin $error("reconfig pulse while PLL busy"); assert_errs++; end
	a_rc_done: assert property (@(posedge clk_sys) disable iff (reset_i)
		pll_reconfig_o ##1 !pll_busy_i |=> ##1 pix_clk_ena_o)
		else begin $error("pixel clock not restored"); assert_errs++; end
	a_rc_wdog: assert property (@(posedge clk_sys) disable iff (reset_i)
		pll_reset_o |-> $past(pll_busy_i) && !pix_clk_ena_o)
		else begin $error("PLL reset without busy timeout"); assert_errs++; end

	a_sync: assert property (@(posedge clk_sys) disable iff (reset_i)
		ce_pix_i |=> hs_o == $past(hs_i) && vs_o == $past(vs_i))
		else begin $error("sync not registered on pixel enable"); assert_errs++; end
	a_hold: assert property (@(posedge clk_sys) disable iff (reset_i)
		!ce_pix_i |=> $stable(hs_o) && $stable(vs_o) && $stable(r_o) &&
			$stable(g_o) && $stable(b_o))
		else begin $error("video output changed without pixel enable"); assert_errs++; end
	a_blank: assert property (@(posedge clk_sys) disable iff (reset_i)
		ce_pix_i && hi_cnt < limit |=> r_o == '0 && g_o == '0 && b_o == '0)
		else begin $error("colour not blanked in back porch"); assert_errs++; end
	a_active: assert property (@(posedge clk_sys) disable iff (reset_i)
		ce_pix_i && hs_o && hi_cnt >= limit
			|=> r_o == $past(r_i) && g_o == $past(g_i) && b_o == $past(b_i))
		else begin $error("colour not passed after porch"); assert_errs++; end

endmodule

bind archie_support_top archie_support_asserts asserts_inst (.*);

/* hw/archie_support_top.sv */
module archie_support_top
	import archie_cfg_pkg::*;
	import archie_bus_pkg::*;
#(
	parameter int CLKEN_DIV        = CLKEN_DIV_DEF,
	parameter int RECONFIG_TIMEOUT = RECONFIG_TIMEOUT_DEF
) (
	input  logic                 clk_sys,
	input  logic                 reset_i,

	output logic                 clk2m_en_o,
	output logic                 clk8m_en_o,

	// loader and boot
	input  logic                 dl_active_i,
	input  dl_index_t            dl_index_i,
	input  logic                 dl_wr_i,
	input  logic [DL_ADR_W-1:0]  dl_addr_i,
	input  logic [7:0]           dl_data_i,
	input  logic                 ram_ready_i,
	input  logic                 button_reset_i,
	output logic                 core_reset_o,

	// core master
	input  logic                 core_cyc_i,
	input  logic                 core_stb_i,
	input  logic                 core_we_i,
	input  logic [WB_SEL_W-1:0]  core_sel_i,
	input  logic [WB_ADR_W-1:0]  core_adr_i,
	input  logic [WB_DATA_W-1:0] core_dat_i,
	output logic [WB_DATA_W-1:0] core_dat_o,
	output logic                 core_ack_o,

	// memory slave
	output logic                 ram_cyc_o,
	output logic                 ram_stb_o,
	output logic                 ram_we_o,
	output logic [WB_SEL_W-1:0]  ram_sel_o,
	output logic [WB_ADR_W-1:0]  ram_adr_o,
	output logic [WB_DATA_W-1:0] ram_dat_o,
	input  logic                 ram_ack_i,
	input  logic [WB_DATA_W-1:0] ram_dat_i,

	// pixel clock PLL
	input  pixclk_sel_t          pixbase_sel_i,
	input  logic                 pll_busy_i,
	output logic                 pll_write_from_rom_o,
	output logic                 pll_reconfig_o,
	output logic                 pll_reset_o,
	output logic                 pix_clk_ena_o,

	// video
	input  logic                 ce_pix_i,
	input  logic                 hs_i,
	input  logic                 vs_i,
	input  logic [COLOR_W-1:0]   r_i,
	input  logic [COLOR_W-1:0]   g_i,
	input  logic [COLOR_W-1:0]   b_i,
	output logic                 hs_o,
	output logic                 vs_o,
	output logic [COLOR_W-1:0]   r_o,
	output logic [COLOR_W-1:0]   g_o,
	output logic [COLOR_W-1:0]   b_o
);

	logic loader_owns_bus;

	// read data goes straight back to the core
	assign core_dat_o = ram_dat_i;

	clken_gen #(
		.CLKEN_DIV(CLKEN_DIV)
	) clken_gen_inst (
		.clk_sys   (clk_sys),
		.reset_i   (reset_i),
		.clk2m_en_o(clk2m_en_o),
		.clk8m_en_o(clk8m_en_o)
	);

	sys_ctrl #(
		.RECONFIG_TIMEOUT(RECONFIG_TIMEOUT)
	) sys_ctrl_inst (
		.clk_sys             (clk_sys),
		.reset_i             (reset_i),
		.dl_active_i         (dl_active_i),
		.dl_index_i          (dl_index_i),
		.ram_ready_i         (ram_ready_i),
		.button_reset_i      (button_reset_i),
		.pixbase_sel_i       (pixbase_sel_i),
		.pll_busy_i          (pll_busy_i),
		.loader_owns_bus_o   (loader_owns_bus),
		.core_reset_o        (core_reset_o),
		.pix_clk_ena_o       (pix_clk_ena_o),
		.pll_write_from_rom_o(pll_write_from_rom_o),
		.pll_reconfig_o      (pll_reconfig_o),
		.pll_reset_o         (pll_reset_o)
	);

	loader_bridge loader_bridge_inst (
		.clk_sys          (clk_sys),
		.reset_i          (reset_i),
		.loader_owns_bus_i(loader_owns_bus),
		.dl_wr_i          (dl_wr_i),
		.dl_addr_i        (dl_addr_i),
		.dl_data_i        (dl_data_i),
		.core_cyc_i       (core_cyc_i),
		.core_stb_i       (core_stb_i),
		.core_we_i        (core_we_i),
		.core_sel_i       (core_sel_i),
		.core_adr_i       (core_adr_i),
		.core_dat_i       (core_dat_i),
		.core_ack_o       (core_ack_o),
		.ram_cyc_o        (ram_cyc_o),
		.ram_stb_o        (ram_stb_o),
		.ram_we_o         (ram_we_o),
		.ram_sel_o        (ram_sel_o),
		.ram_adr_o        (ram_adr_o),
		.ram_dat_o        (ram_dat_o),
		.ram_ack_i        (ram_ack_i)
	);

	porch_blanker porch_blanker_inst (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.ce_pix_i     (ce_pix_i),
		.pixbase_sel_i(pixbase_sel_i),
		.hs_i         (hs_i),
		.vs_i         (vs_i),
		.r_i          (r_i),
		.g_i          (g_i),
		.b_i          (b_i),
		.hs_o         (hs_o),
		.vs_o         (vs_o),
		.r_o          (r_o),
		.g_o          (g_o),
		.b_o          (b_o)
	);

endmodule

/* hw/porch_blanker.sv */
module porch_blanker import archie_cfg_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset_i,
	input  logic               ce_pix_i,
	input  pixclk_sel_t        pixbase_sel_i,
	input  logic               hs_i,
	input  logic               vs_i,
	input  logic [COLOR_W-1:0] r_i,
	input  logic [COLOR_W-1:0] g_i,
	input  logic [COLOR_W-1:0] b_i,
	output logic               hs_o,
	output logic               vs_o,
	output logic [COLOR_W-1:0] r_o,
	output logic [COLOR_W-1:0] g_o,
	output logic [COLOR_W-1:0] b_o
);

	logic [PORCH_CNT_W-1:0] pix_cnt_q;
	logic                   tv_mode;
	logic                   porch_done;

	// 256 clocks in TV modes, 64 in VGA modes
	assign tv_mode    = pixbase_sel_i[0] == pixbase_sel_i[1];
	assign porch_done = tv_mode ? &pix_cnt_q : &pix_cnt_q[PORCH_VGA_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			pix_cnt_q <= '0;
			hs_o      <= 1'b0;
			vs_o      <= 1'b0;
			r_o       <= '0;
			g_o       <= '0;
			b_o       <= '0;
		end else begin
			// restart on every line while sync is low
			if (!hs_o)
				pix_cnt_q <= '0;
			else if (!porch_done)
				pix_cnt_q <= pix_cnt_q + 1'b1;

			if (ce_pix_i) begin
				hs_o <= hs_i;
				vs_o <= vs_i;
				r_o  <= porch_done ? r_i : '0;
				g_o  <= porch_done ? g_i : '0;
				b_o  <= porch_done ? b_i : '0;
			end
		end
	end

endmodule

/* hw/loader_bridge.sv */
module loader_bridge import archie_bus_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset_i,

	input  logic                 loader_owns_bus_i,

	// host loader byte port
	input  logic                 dl_wr_i,
	input  logic [DL_ADR_W-1:0]  dl_addr_i,
	input  logic [7:0]           dl_data_i,

	// core Wishbone master
	input  logic                 core_cyc_i,
	input  logic                 core_stb_i,
	input  logic                 core_we_i,
	input  logic [WB_SEL_W-1:0]  core_sel_i,
	input  logic [WB_ADR_W-1:0]  core_adr_i,
	input  logic [WB_DATA_W-1:0] core_dat_i,
	output logic                 core_ack_o,

	// towards the memory slave
	output logic                 ram_cyc_o,
	output logic                 ram_stb_o,
	output logic                 ram_we_o,
	output logic [WB_SEL_W-1:0]  ram_sel_o,
	output logic [WB_ADR_W-1:0]  ram_adr_o,
	output logic [WB_DATA_W-1:0] ram_dat_o,
	input  logic                 ram_ack_i
);

	logic [DL_ADR_W-1:0]  dl_addr_q;
	logic [7:0]           dl_data_q;
	logic                 dl_stb_q;
	logic [WB_SEL_W-1:0]  dl_sel;
	logic [WB_ADR_W-1:0]  dl_adr;
	logic [WB_DATA_W-1:0] dl_dat;

	always_ff @(posedge clk_sys) begin
		if (reset_i)
			dl_stb_q <= 1'b0;
		else if (dl_wr_i && loader_owns_bus_i)
			dl_stb_q <= 1'b1;
		else if (ram_ack_i)
			dl_stb_q <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) begin
			dl_addr_q <= dl_addr_i;
			dl_data_q <= dl_data_i;
		end
	end

	// byte lane from the low address bits
	assign dl_sel = WB_SEL_W'(1) << dl_addr_q[1:0];
	assign dl_dat = {WB_LANES{dl_data_q}};
	assign dl_adr = {{(WB_ADR_W - DL_ADR_W){1'b0}}, dl_addr_q[DL_ADR_W-1:2], 2'b00};

	assign ram_cyc_o = loader_owns_bus_i ? dl_stb_q : core_cyc_i;
	assign ram_stb_o = loader_owns_bus_i ? dl_stb_q : core_stb_i;
	assign ram_we_o  = loader_owns_bus_i ? 1'b1     : core_we_i;
	assign ram_sel_o = loader_owns_bus_i ? dl_sel   : core_sel_i;
	assign ram_dat_o = loader_owns_bus_i ? dl_dat   : core_dat_i;
	assign ram_adr_o = loader_owns_bus_i ? dl_adr   : {core_adr_i[WB_ADR_W-1:2], 2'b00};

	// core sees no acknowledge while the loader writes
	assign core_ack_o = loader_owns_bus_i ? 1'b0 : ram_ack_i;

endmodule

/* hw/sys_ctrl.sv */
module sys_ctrl
	import archie_cfg_pkg::*;
	import archie_bus_pkg::*;
#(
	parameter int RECONFIG_TIMEOUT = RECONFIG_TIMEOUT_DEF
) (
	input  logic        clk_sys,
	input  logic        reset_i,

	// boot
	input  logic        dl_active_i,
	input  dl_index_t   dl_index_i,
	input  logic        ram_ready_i,
	input  logic        button_reset_i,

	// pixel clock reconfiguration
	input  pixclk_sel_t pixbase_sel_i,
	input  logic        pll_busy_i,

	output logic        loader_owns_bus_o,
	output logic        core_reset_o,
	output logic        pix_clk_ena_o,
	output logic        pll_write_from_rom_o,
	output logic        pll_reconfig_o,
	output logic        pll_reset_o
);

	localparam int TMO_W = $clog2(RECONFIG_TIMEOUT + 1);

	logic          owns_bus;
	logic          owns_q;
	logic          dl_end_q;
	logic          rom_ready_q;

	reconf_state_t state_q;
	pixclk_sel_t   sel_q;
	logic [TMO_W-1:0] wdog_q;
	logic          clk_ena_q;
	logic          wr_rom_q;
	logic          reconfig_q;
	logic          pll_rst_q;

	// only ROM images are routed into memory
	assign owns_bus = dl_active_i &&
	                  (dl_index_i == dl_rom_a || dl_index_i == dl_rom_b);

	assign loader_owns_bus_o = owns_bus;

	// hold the core in reset until memory and ROM are both usable
	assign core_reset_o = ~ram_ready_i | ~rom_ready_q | button_reset_i;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			owns_q      <= 1'b0;
			dl_end_q    <= 1'b0;
			rom_ready_q <= 1'b0;
		end else begin
			owns_q   <= owns_bus;
			// falling edge of the ROM download
			dl_end_q <= owns_q & ~owns_bus;
			if (dl_end_q)
				rom_ready_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			state_q    <= rc_idle;
			sel_q      <= pix_36;
			wdog_q     <= '0;
			clk_ena_q  <= 1'b1;
			wr_rom_q   <= 1'b0;
			reconfig_q <= 1'b0;
			pll_rst_q  <= 1'b0;
		end else begin
			// single cycle pulses by default
			wr_rom_q   <= 1'b0;
			reconfig_q <= 1'b0;
			pll_rst_q  <= 1'b0;

			case (state_q)
				rc_idle: begin
					clk_ena_q <= 1'b1;
					sel_q     <= pixbase_sel_i;
					if (pixbase_sel_i != sel_q) begin
						// stop the pixel clock and fetch new settings
						clk_ena_q <= 1'b0;
						wr_rom_q  <= 1'b1;
						state_q   <= rc_load;
					end
				end
				rc_load: begin
					state_q <= rc_wait;
				end
				rc_wait: begin
					if (!pll_busy_i) begin
						reconfig_q <= 1'b1;
						wdog_q     <= TMO_W'(RECONFIG_TIMEOUT);
						state_q    <= rc_run;
					end
				end
				rc_run: begin
					wdog_q <= wdog_q - 1'b1;
					if (!reconfig_q && !pll_busy_i) begin
						state_q <= rc_idle;
					end else if (wdog_q == TMO_W'(1)) begin
						// PLL stuck in busy
						pll_rst_q <= 1'b1;
						state_q   <= rc_idle;
					end
				end
				default: begin
					state_q <= rc_idle;
				end
			endcase
		end
	end

	assign pix_clk_ena_o        = clk_ena_q;
	assign pll_write_from_rom_o = wr_rom_q;
	assign pll_reconfig_o       = reconfig_q;
	assign pll_reset_o          = pll_rst_q;

endmodule

/* hw/clken_gen.sv */
module clken_gen import archie_cfg_pkg::*; #(
	parameter int CLKEN_DIV = CLKEN_DIV_DEF
) (
	input  logic clk_sys,
	input  logic reset_i,
	output logic clk2m_en_o,
	output logic clk8m_en_o
);

	localparam int CNT_W   = $clog2(CLKEN_DIV);
	localparam int QUARTER = CLKEN_DIV / 4;

	logic [CNT_W-1:0] cnt_q;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			cnt_q      <= '0;
			clk2m_en_o <= 1'b0;
			clk8m_en_o <= 1'b0;
		end else begin
			if (cnt_q == CNT_W'(CLKEN_DIV - 1))
				cnt_q <= '0;
			else
				cnt_q <= cnt_q + 1'b1;

			clk2m_en_o <= (cnt_q == '0);
			// four evenly spaced points per period
			clk8m_en_o <= (cnt_q == '0) ||
			              (cnt_q == CNT_W'(QUARTER)) ||
			              (cnt_q == CNT_W'(2 * QUARTER)) ||
			              (cnt_q == CNT_W'(3 * QUARTER));
		end
	end

endmodule

/* hw/archie_bus_pkg.sv */
package archie_bus_pkg;

	// Wishbone memory bus between core, loader and SDRAM controller
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = 4;
	localparam int WB_ADR_W  = 26;

	// byte address width of the firmware loader
	localparam int DL_ADR_W = 24;

	// byte lanes per bus word
	localparam int WB_LANES = WB_DATA_W / 8;

	// image index reported by the host loader
	// only the two ROM images are written into memory
	typedef enum logic [7:0] {
		dl_menu  = 8'd0,
		dl_rom_a = 8'd1,
		dl_rom_b = 8'd2,
		dl_cmos  = 8'd3
	} dl_index_t;

endpackage

/* hw/archie_cfg_pkg.sv */
package archie_cfg_pkg;

	// pixel base clock selected by the core
	// modes with both bits equal run at TV rates
	typedef enum logic [1:0] {
		pix_24 = 2'b00,
		pix_25 = 2'b01,
		pix_36 = 2'b10
	} pixclk_sel_t;

	// PLL reconfiguration sequencer states
	typedef enum logic [1:0] {
		rc_idle = 2'b00,
		rc_load = 2'b01,
		rc_wait = 2'b10,
		rc_run  = 2'b11
	} reconf_state_t;

	// watchdog length in clk_sys cycles while the PLL reports busy
	localparam int RECONFIG_TIMEOUT_DEF = 1000;

	// clk_sys divide ratio for the 2 MHz enable
	// 8 MHz enable runs at a quarter of this
	localparam int CLKEN_DIV_DEF = 20;

	// bits per colour channel from the core
	localparam int COLOR_W = 4;

	// porch lengths in clk_sys cycles
	localparam int PORCH_CNT_W = 8;
	localparam int PORCH_VGA_W = 6;

endpackage
